//--- rtl/spiPkg.sv
// SPI side constants; Mode 0 only, one byte per start, channel count fixed at build time
package spiPkg;

	// --------------------
	// Widths with meaning
	// --------------------

	// One SPI data byte, shifted MSB first
	typedef logic [7:0] spiByteT;

	// SCK prescaler reload value
	// Half-period in system clocks is value + 1
	typedef logic [7:0] spiDivT;

	// Counts SCK edges within one byte, 0 to 16
	typedef logic [4:0] spiTickT;

	// --------------------
	// Fixed values
	// --------------------

	// Number of byte engines in the bridge
	localparam int numChannels = 2;

	// Divider after reset, gives 4 clocks per SCK half
	localparam spiDivT divResetVal = 8'd3;

	// Rise and fall for each of 8 bits
	localparam spiTickT sckEdges = 5'd16;

endpackage : spiPkg

//--- rtl/wbPkg.sv
// Wishbone classic side; 8-bit data, word addresses only, no byte selects or bursts
package wbPkg;

	// --------------------
	// Bus widths
	// --------------------

	// Word address, eight registers decoded
	typedef logic [2:0] wbAdrT;

	// Data bus, one byte
	typedef logic [7:0] wbDatT;

	// --------------------
	// Register map
	// --------------------

	// Divider, read and write
	localparam wbAdrT regDiv    = 3'd0;
	// Busy in bits 1..0, done in bits 3..2
	localparam wbAdrT regStatus = 3'd1;
	// Write only, a write starts a byte
	localparam wbAdrT regTx0    = 3'd2;
	localparam wbAdrT regTx1    = 3'd3;
	// Read only, read clears done
	localparam wbAdrT regRx0    = 3'd4;
	localparam wbAdrT regRx1    = 3'd5;

	// Addresses 6 and 7 are unused
	// Reads give zero, writes are ignored

endpackage : wbPkg

//--- rtl/wbSpiCtrl.sv
// Every access acked one clock after request, then one idle clock; no wait states
`timescale 1ns/1ps

module wbSpiCtrl
	import spiPkg::*, wbPkg::*;
(
	input  logic                   iSysClk,
	input  logic                   rstN,
	// Wishbone slave
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  wbAdrT                  adr,
	input  wbDatT                  datIn,
	output wbDatT                  datOut,
	output logic                   ack,
	// To the byte engines
	output logic                   sckTick,
	output logic [numChannels-1:0] start,
	output spiByteT                txByte,
	input  logic [numChannels-1:0] busy,
	// Read path through the collector
	output logic                   rdEn,
	output wbAdrT                  rdAdr,
	input  wbDatT                  rdData
);

	typedef enum logic {ctrlIdle, ctrlAck} ctrlStateT;

	ctrlStateT state;
	spiDivT    divReg;
	spiDivT    presCnt;
	logic      req;
	logic      wrReq;
	logic      divWr;

	// --------------------
	// Request decode
	// --------------------

	// Only idle state takes a new access
	assign req   = (state == ctrlIdle) && cyc && stb;
	assign wrReq = req && we;
	assign divWr = wrReq && (adr == regDiv);

	// Collector sees the read in the request clock
	// so done clears on the same edge as ack rises
	assign rdEn  = req && !we;
	assign rdAdr = adr;

	assign ack   = (state == ctrlAck);

	// Ack for one clock, then back to idle
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			state <= ctrlIdle;
		else if (req)
			state <= ctrlAck;
		else
			state <= ctrlIdle;
	end

	// --------------------
	// Divider and prescaler
	// --------------------

	// Free running; a divider write reloads the count at once
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			divReg  <= divResetVal;
			presCnt <= divResetVal;
			sckTick <= 1'b0;
		end
		else if (divWr)
		begin
			divReg  <= datIn;
			presCnt <= datIn;
			sckTick <= 1'b0;
		end
		else if (presCnt == '0)
		begin
			// Count div..0 gives div+1 clocks per tick
			presCnt <= divReg;
			sckTick <= 1'b1;
		end
		else
		begin
			presCnt <= presCnt - 1'b1;
			sckTick <= 1'b0;
		end
	end

	// --------------------
	// Start dispatch
	// --------------------

	// Start lands in the ack clock
	// Busy channel just drops the write
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			start <= '0;
		else
			for (int ch = 0; ch < numChannels; ch++)
				start[ch] <= wrReq && (adr == wbAdrT'(regTx0 + ch)) && !busy[ch];
	end

	// Data paths, valid whenever their strobe is
	always_ff @(posedge iSysClk)
	begin
		if (wrReq)
			txByte <= datIn;
		// Divider lives here, the rest comes from the collector
		if (rdEn)
			datOut <= (adr == regDiv) ? divReg : rdData;
	end

	// --------------------
	// Checks
	// --------------------

	// Master holds its request until ack
	ackHeld : assert property (@(posedge iSysClk) disable iff (!rstN)
		ack |-> (cyc && stb))
		else $error("ack without cyc and stb");

	ackSingle : assert property (@(posedge iSysClk) disable iff (!rstN)
		ack |=> !ack)
		else $error("ack held for two clocks");

endmodule : wbSpiCtrl

//--- rtl/spiByteMaster.sv
// Mode 0 byte engine, MSB first; CS setup and hold only as long as sckTick alignment gives
`timescale 1ns/1ps

module spiByteMaster
	import spiPkg::*;
(
	input  logic    iSysClk,
	input  logic    rstN,
	// Control
	input  logic    sckTick,
	input  logic    start,
	input  spiByteT txByte,
	output logic    busy,
	output logic    rxValid,
	output spiByteT rxByte,
	// SPI pins
	output logic    spiCsN,
	output logic    spiSck,
	output logic    spiMosi,
	input  logic    spiMiso
);

	typedef enum logic [1:0] {engIdle, engShift, engFinish} engStateT;

	engStateT state;
	spiTickT  tickCnt;
	spiByteT  txShift;
	spiByteT  rxShift;
	logic     riseTick;
	logic     fallTick;
	logic     lastEdge;

	// --------------------
	// Edge decode
	// --------------------

	// Tick count even before the tick means SCK goes up
	assign riseTick = (state == engShift) && sckTick && !tickCnt[0];
	assign fallTick = (state == engShift) && sckTick && tickCnt[0];
	// Tick 16, SCK falls for the last time
	assign lastEdge = (tickCnt == spiTickT'(sckEdges - 1'b1));

	// --------------------
	// Engine FSM
	// --------------------

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state   <= engIdle;
			tickCnt <= '0;
			busy    <= 1'b0;
			rxValid <= 1'b0;
			spiCsN  <= 1'b1;
			spiSck  <= 1'b0;
			spiMosi <= 1'b0;
		end
		else
		begin
			// Single clock strobe
			rxValid <= 1'b0;
			case (state)
				engIdle:
				begin
					// CS low and bit 7 out together
					if (start)
					begin
						state   <= engShift;
						tickCnt <= '0;
						busy    <= 1'b1;
						spiCsN  <= 1'b0;
						spiMosi <= txByte[7];
					end
				end
				engShift:
				begin
					if (riseTick)
					begin
						tickCnt <= tickCnt + 1'b1;
						spiSck  <= 1'b1;
					end
					else if (fallTick)
					begin
						// Next bit out on falling SCK
						tickCnt <= tickCnt + 1'b1;
						spiSck  <= 1'b0;
						spiMosi <= txShift[7];
						if (lastEdge)
							state <= engFinish;
					end
				end
				engFinish:
				begin
					// Tick 17 closes the byte
					if (sckTick)
					begin
						state   <= engIdle;
						busy    <= 1'b0;
						rxValid <= 1'b1;
						spiCsN  <= 1'b1;
					end
				end
				default:
					state <= engIdle;
			endcase
		end
	end

	// --------------------
	// Shift registers
	// --------------------

	// Bit 7 already on the pin at start, so load the rest
	always_ff @(posedge iSysClk)
	begin
		if ((state == engIdle) && start)
			txShift <= {txByte[6:0], 1'b0};
		else if (fallTick)
			txShift <= {txShift[6:0], 1'b0};
		// Sampled on rising SCK
		if (riseTick)
			rxShift <= {rxShift[6:0], spiMiso};
	end

	// Stable from last rise until next start
	assign rxByte = rxShift;

	// --------------------
	// Checks
	// --------------------

	idleCsHigh : assert property (@(posedge iSysClk) disable iff (!rstN)
		(state == engIdle) |-> spiCsN)
		else $error("CS low while engine idle");

	// Controller must gate start with busy
	noStartBusy : assert property (@(posedge iSysClk) disable iff (!rstN)
		start |-> !busy)
		else $error("start while busy");

	sckLowOutsideCs : assert property (@(posedge iSysClk) disable iff (!rstN)
		spiCsN |-> !spiSck)
		else $error("SCK high with CS deasserted");

endmodule : spiByteMaster

//--- rtl/spiRxCollect.sv
// One byte latch per channel, no overrun flag; an unread byte is simply overwritten
`timescale 1ns/1ps

module spiRxCollect
	import spiPkg::*, wbPkg::*;
(
	input  logic                   iSysClk,
	input  logic                   rstN,
	// From the engines
	input  logic [numChannels-1:0] rxValid,
	input  spiByteT                rxByte [numChannels],
	input  logic [numChannels-1:0] busy,
	// Read port from the controller
	input  logic                   rdEn,
	input  wbAdrT                  rdAdr,
	output wbDatT                  rdData
);

	spiByteT                rxLatch [numChannels];
	logic [numChannels-1:0] done;
	logic [numChannels-1:0] busyEff;

	// --------------------
	// Latches and flags
	// --------------------

	// Byte held until the next one arrives
	always_ff @(posedge iSysClk)
	begin
		for (int ch = 0; ch < numChannels; ch++)
			if (rxValid[ch])
				rxLatch[ch] <= rxByte[ch];
	end

	// New byte wins over a read clear in the same clock
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			done <= '0;
		else
			for (int ch = 0; ch < numChannels; ch++)
			begin
				if (rxValid[ch])
					done[ch] <= 1'b1;
				else if (rdEn && (rdAdr == wbAdrT'(regRx0 + ch)))
					done[ch] <= 1'b0;
			end
	end

	// --------------------
	// Read mux
	// --------------------

	// Byte still on its way to the latch counts as busy,
	// so status busy falls exactly when done rises
	assign busyEff = busy | rxValid;

	always_comb
	begin
		rdData = '0;
		if (rdAdr == regStatus)
			rdData = wbDatT'({done, busyEff});
		for (int ch = 0; ch < numChannels; ch++)
			if (rdAdr == wbAdrT'(regRx0 + ch))
				rdData = rxLatch[ch];
	end

endmodule : spiRxCollect

//--- rtl/spiBridgeTop.sv
// Two-channel SPI master behind Wishbone; shared SCK divider, SPI pins plain in/out
`timescale 1ns/1ps

module spiBridgeTop
	import spiPkg::*, wbPkg::*;
(
	input  logic                   iSysClk,
	input  logic                   rstN,
	// Wishbone classic slave
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  wbAdrT                  adr,
	input  wbDatT                  datIn,
	output wbDatT                  datOut,
	output logic                   ack,
	// SPI, one bit per channel
	output logic [numChannels-1:0] spiCsN,
	output logic [numChannels-1:0] spiSck,
	output logic [numChannels-1:0] spiMosi,
	input  logic [numChannels-1:0] spiMiso
);

	// Controller to engines
	logic                   sckTick;
	logic [numChannels-1:0] start;
	spiByteT                txByte;
	// Engines back
	logic [numChannels-1:0] busy;
	logic [numChannels-1:0] rxValid;
	spiByteT                rxByte [numChannels];
	// Read path
	logic                   rdEn;
	wbAdrT                  rdAdr;
	wbDatT                  rdData;

	// --------------------
	// Bus side
	// --------------------

	wbSpiCtrl uCtrl (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.cyc     (cyc),
		.stb     (stb),
		.we      (we),
		.adr     (adr),
		.datIn   (datIn),
		.datOut  (datOut),
		.ack     (ack),
		.sckTick (sckTick),
		.start   (start),
		.txByte  (txByte),
		.busy    (busy),
		.rdEn    (rdEn),
		.rdAdr   (rdAdr),
		.rdData  (rdData)
	);

	// --------------------
	// Byte engines
	// --------------------

	// All share sckTick and txByte, start picks the channel
	for (genvar gi = 0; gi < numChannels; gi++)
	begin : genEngine
		spiByteMaster uEngine (
			.iSysClk (iSysClk),
			.rstN    (rstN),
			.sckTick (sckTick),
			.start   (start[gi]),
			.txByte  (txByte),
			.busy    (busy[gi]),
			.rxValid (rxValid[gi]),
			.rxByte  (rxByte[gi]),
			.spiCsN  (spiCsN[gi]),
			.spiSck  (spiSck[gi]),
			.spiMosi (spiMosi[gi]),
			.spiMiso (spiMiso[gi])
		);
	end

	// Receive side and status
	spiRxCollect uCollect (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.rxValid (rxValid),
		.rxByte  (rxByte),
		.busy    (busy),
		.rdEn    (rdEn),
		.rdAdr   (rdAdr),
		.rdData  (rdData)
	);

endmodule : spiBridgeTop

//--- bench/spiBridgeChecker.sv
// Passive watcher; predictions assume MISO = MOSI on channel 0, inverted on channel 1, one shared divider
`timescale 1ns/1ps

module spiBridgeChecker
	import spiPkg::*, wbPkg::*;
(
	input  logic                   iSysClk,
	input  logic                   rstN,
	// Wishbone port as seen at the DUT
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  wbAdrT                  adr,
	input  wbDatT                  datIn,
	input  wbDatT                  datOut,
	input  logic                   ack,
	// SPI pins
	input  logic [numChannels-1:0] spiCsN,
	input  logic [numChannels-1:0] spiSck,
	input  logic [numChannels-1:0] spiMosi,
	output int                     errCount,
	output int                     windowCount [numChannels]
);

	spiByteT                expRx [numChannels];
	spiByteT                expTx [numChannels];
	logic [numChannels-1:0] expValid;
	logic [numChannels-1:0] csAtReq;
	spiDivT                 lastDiv;
	logic [numChannels-1:0] prevCs;
	logic [numChannels-1:0] prevSck;
	logic [numChannels-1:0] haveEdge;
	int                     riseCnt [numChannels];
	int                     halfCnt [numChannels];
	int                     busErrs;
	int                     pinErrs;

	assign errCount = busErrs + pinErrs;

	// Prints the error line, caller keeps the count
	function automatic bit isMismatch(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("Mismatch at %0t ns: %s is 'h%0h, expected 'h%0h", $time, name, got, exp);
			return 1'b1;
		end
		return 1'b0;
	endfunction

	// --------------------
	// Bus side
	// --------------------

	// Access counts once ack is seen with the request still held
	always @(posedge iSysClk or negedge rstN)
	begin : busWatch
		int n;
		n = 0;
		if (!rstN)
		begin
			busErrs  <= 0;
			lastDiv  <= divResetVal;
			expValid <= '0;
			csAtReq  <= '1;
		end
		else
		begin
			// Idle state of each engine in the request clock
			if (cyc && stb && !ack)
				csAtReq <= spiCsN;
			if (cyc && stb && ack)
			begin
				if (we && (adr == regDiv))
					lastDiv <= datIn;
				for (int ch = 0; ch < numChannels; ch++)
				begin
					// Busy channel drops the write, prediction stays
					if (we && (adr == wbAdrT'(regTx0 + ch)) && csAtReq[ch])
					begin
						expTx[ch]    <= datIn;
						expRx[ch]    <= (ch == 1) ? ~datIn : datIn;
						expValid[ch] <= 1'b1;
					end
					if (!we && (adr == wbAdrT'(regRx0 + ch)) && expValid[ch])
						if (isMismatch($sformatf("regRx%0d", ch), int'(datOut), int'(expRx[ch])))
							n++;
				end
			end
			busErrs <= busErrs + n;
		end
	end

	// --------------------
	// SPI pins
	// --------------------

	always @(posedge iSysClk or negedge rstN)
	begin : pinWatch
		int n;
		n = 0;
		if (!rstN)
		begin
			pinErrs  <= 0;
			prevCs   <= '1;
			prevSck  <= '0;
			haveEdge <= '0;
			for (int ch = 0; ch < numChannels; ch++)
			begin
				riseCnt[ch]     <= 0;
				halfCnt[ch]     <= 0;
				windowCount[ch] <= 0;
			end
		end
		else
		begin
			for (int ch = 0; ch < numChannels; ch++)
			begin
				prevCs[ch]  <= spiCsN[ch];
				prevSck[ch] <= spiSck[ch];
				// Window opens
				if (prevCs[ch] && !spiCsN[ch])
				begin
					riseCnt[ch]  <= 0;
					haveEdge[ch] <= 1'b0;
				end
				// Window closes, one byte means 8 rises
				else if (!prevCs[ch] && spiCsN[ch])
				begin
					if (isMismatch($sformatf("SCK rises on channel %0d", ch), riseCnt[ch], 8))
						n++;
					windowCount[ch] <= windowCount[ch] + 1;
				end
				if (spiSck[ch] != prevSck[ch])
				begin
					// First edge of a window has nothing to measure from
					if (haveEdge[ch])
						if (isMismatch($sformatf("SCK half-period on channel %0d", ch),
							halfCnt[ch], int'(lastDiv) + 1))
							n++;
					halfCnt[ch]  <= 1;
					haveEdge[ch] <= 1'b1;
					if (spiSck[ch])
					begin
						// MSB first, bit held through the whole high phase
						if (riseCnt[ch] < 8)
							if (isMismatch($sformatf("MOSI on channel %0d", ch),
								int'(spiMosi[ch]), int'(expTx[ch][7 - riseCnt[ch]])))
								n++;
						riseCnt[ch] <= riseCnt[ch] + 1;
					end
				end
				else
					halfCnt[ch] <= halfCnt[ch] + 1;
			end
			pinErrs <= pinErrs + n;
		end
	end

endmodule : spiBridgeChecker

//--- bench/tbSpiBridge.sv
// 25 MHz clock; MISO looped from MOSI, inverted on channel 1; every wait ends at a poll limit
`timescale 1ns/1ps

module tbSpiBridge
	import spiPkg::*, wbPkg::*;
();

	localparam int numRows   = 12;
	localparam int ackLimit  = 8;
	localparam int pollLimit = 300;

	logic                   iSysClk;
	logic                   rstN;
	logic                   cyc;
	logic                   stb;
	logic                   we;
	wbAdrT                  adr;
	wbDatT                  datIn;
	wbDatT                  datOut;
	logic                   ack;
	logic [numChannels-1:0] spiCsN;
	logic [numChannels-1:0] spiSck;
	logic [numChannels-1:0] spiMosi;
	logic [numChannels-1:0] spiMiso;
	int                     chkErrs;
	int                     windowCount [numChannels];

	// Stimulus table, one transfer per row
	int                     stimCh   [numRows];
	spiByteT                stimByte [numRows];
	spiDivT                 stimDiv  [numRows];

	logic [16:0]            lfsr;
	spiDivT                 curDiv;
	int                     tbErrs;
	int                     errMark;
	int                     testsPassed;
	int                     testsFailed;

	initial
	begin
		iSysClk = 1'b0;
		forever #20 iSysClk = ~iSysClk;
	end

	// Loopback wiring
	assign spiMiso[0] = spiMosi[0];
	assign spiMiso[1] = ~spiMosi[1];

	spiBridgeTop u_dut (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.cyc     (cyc),
		.stb     (stb),
		.we      (we),
		.adr     (adr),
		.datIn   (datIn),
		.datOut  (datOut),
		.ack     (ack),
		.spiCsN  (spiCsN),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiMiso (spiMiso)
	);

	spiBridgeChecker u_chk (
		.iSysClk     (iSysClk),
		.rstN        (rstN),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.datIn       (datIn),
		.datOut      (datOut),
		.ack         (ack),
		.spiCsN      (spiCsN),
		.spiSck      (spiSck),
		.spiMosi     (spiMosi),
		.errCount    (chkErrs),
		.windowCount (windowCount)
	);

	// --------------------
	// Helpers
	// --------------------

	// Fibonacci x^17 + x^14 + 1
	function automatic logic nextRandBit();
		logic fb;
		fb   = lfsr[16] ^ lfsr[13];
		lfsr = {lfsr[15:0], fb};
		return fb;
	endfunction

	function automatic spiByteT randomByte();
		spiByteT b;
		b = '0;
		for (int i = 0; i < 8; i++)
			b = {b[6:0], nextRandBit()};
		return b;
	endfunction

	task automatic noteFailure(input string what);
		$display("Failure at %0t ns: %s", $time, what);
		tbErrs++;
	endtask

	task automatic expectEq(input string name, input int got, input int exp);
		if (u_chk.isMismatch(name, got, exp))
			tbErrs++;
	endtask

	// Held until ack, released after the ack clock
	task automatic accessBus(input logic wr, input wbAdrT a, input wbDatT d, output wbDatT q);
		int waitCnt;
		@(posedge iSysClk);
		#2;
		cyc     = 1'b1;
		stb     = 1'b1;
		we      = wr;
		adr     = a;
		datIn   = d;
		waitCnt = 0;
		@(negedge iSysClk);
		while (!ack && waitCnt < ackLimit)
		begin
			waitCnt++;
			@(negedge iSysClk);
		end
		q = ack ? datOut : '0;
		if (!ack)
			noteFailure($sformatf("no ack for access to address %0d", a));
		else
			// Ack belongs in the clock right after the request clock
			expectEq("ack latency", waitCnt, 1);
		@(posedge iSysClk);
		#2;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic writeReg(input wbAdrT a, input wbDatT d);
		wbDatT unused;
		accessBus(1'b1, a, d, unused);
	endtask

	task automatic readReg(input wbAdrT a, output wbDatT q);
		accessBus(1'b0, a, '0, q);
	endtask

	// Polls status until the masked busy bits clear
	task automatic waitIdle(input logic [numChannels-1:0] mask, output wbDatT status);
		int polls;
		polls = 0;
		readReg(regStatus, status);
		while (((status[numChannels-1:0] & mask) != '0) && polls < pollLimit)
		begin
			polls++;
			readReg(regStatus, status);
		end
		if ((status[numChannels-1:0] & mask) != '0)
			noteFailure("channel still busy after the poll limit");
	endtask

	task automatic setDivider(input spiDivT d);
		wbDatT val;
		writeReg(regDiv, d);
		readReg(regDiv, val);
		expectEq("regDiv", int'(val), int'(d));
		curDiv = d;
	endtask

	// One full transfer, read back through regRx
	task automatic runRow(input int row);
		logic [numChannels-1:0] chMask;
		wbDatT                  status;
		wbDatT                  rxVal;
		int                     ch;
		int                     winStart;
		ch         = stimCh[row];
		chMask     = '0;
		chMask[ch] = 1'b1;
		if (stimDiv[row] != curDiv)
			setDivider(stimDiv[row]);
		winStart = windowCount[ch];
		writeReg(wbAdrT'(regTx0 + ch), stimByte[row]);
		waitIdle(chMask, status);
		expectEq("done before regRx read", int'(status[2 + ch]), 1);
		readReg(wbAdrT'(regRx0 + ch), rxVal);
		readReg(regStatus, status);
		expectEq("done after regRx read", int'(status[2 + ch]), 0);
		expectEq("chip-select windows", windowCount[ch] - winStart, 1);
	endtask

	// Rows 0-3 fixed on ch0, 4-7 random on ch1, 8-11 divider sweep
	task automatic fillTable();
		spiByteT fixed [8];
		fixed = '{8'h00, 8'hFF, 8'hA5, 8'h5A, 8'h3C, 8'hC3, 8'h96, 8'h69};
		for (int r = 0; r < 4; r++)
		begin
			stimCh[r]   = 0;
			stimByte[r] = fixed[r];
			stimDiv[r]  = divResetVal;
		end
		for (int r = 4; r < 8; r++)
		begin
			stimCh[r]   = 1;
			stimByte[r] = randomByte();
			stimDiv[r]  = divResetVal;
		end
		for (int r = 8; r < numRows; r++)
		begin
			stimCh[r]   = r % 2;
			stimByte[r] = fixed[r - 4];
			stimDiv[r]  = (r < 10) ? 8'd0 : 8'd7;
		end
	endtask

	task automatic beginTest();
		errMark = tbErrs + chkErrs;
	endtask

	task automatic endTest(input int num, input string name);
		int errs;
		errs = tbErrs + chkErrs - errMark;
		if (errs == 0)
		begin
			testsPassed++;
			$display("Test %0d %s: pass", num, name);
		end
		else
		begin
			testsFailed++;
			$display("Test %0d %s: FAIL with %0d errors", num, name, errs);
		end
	endtask

	// --------------------
	// Sequence
	// --------------------

	initial
	begin : mainSeq
		wbDatT val;
		int    winA;
		int    winB;
		cyc         = 1'b0;
		stb         = 1'b0;
		we          = 1'b0;
		adr         = '0;
		datIn       = '0;
		rstN        = 1'b0;
		lfsr        = 17'd82486;
		curDiv      = divResetVal;
		tbErrs      = 0;
		testsPassed = 0;
		testsFailed = 0;
		fillTable();
		repeat (3) @(posedge iSysClk);
		#2;
		rstN = 1'b1;

		beginTest();
		@(negedge iSysClk);
		expectEq("spiCsN", int'(spiCsN), (1 << numChannels) - 1);
		expectEq("spiSck", int'(spiSck), 0);
		readReg(regStatus, val);
		expectEq("regStatus", int'(val), 0);
		readReg(regDiv, val);
		expectEq("regDiv", int'(val), int'(divResetVal));
		endTest(1, "reset values");

		beginTest();
		for (int row = 0; row < 4; row++)
			runRow(row);
		endTest(2, "channel 0 table bytes");

		// Channel 0 latch must still hold its last byte
		beginTest();
		for (int row = 4; row < 8; row++)
			runRow(row);
		readReg(regRx0, val);
		endTest(3, "channel 1 random bytes");

		beginTest();
		winA = windowCount[0];
		winB = windowCount[1];
		writeReg(regTx0, 8'hC6);
		writeReg(regTx1, 8'h3B);
		waitIdle('1, val);
		expectEq("done flags", int'(val[3:2]), 3);
		readReg(regRx0, val);
		readReg(regRx1, val);
		expectEq("windows on channel 0", windowCount[0] - winA, 1);
		expectEq("windows on channel 1", windowCount[1] - winB, 1);
		endTest(4, "both channels back to back");

		beginTest();
		for (int row = 8; row < numRows; row++)
			runRow(row);
		endTest(5, "divider 0 and 7");

		// Second write lands while channel 0 shifts
		beginTest();
		if (curDiv != divResetVal)
			setDivider(divResetVal);
		winA = windowCount[0];
		writeReg(regTx0, 8'h81);
		writeReg(regTx0, 8'h7E);
		waitIdle(2'b01, val);
		readReg(regRx0, val);
		expectEq("regRx0", int'(val), 'h81);
		expectEq("windows on channel 0", windowCount[0] - winA, 1);
		endTest(6, "write while busy dropped");

		$display("%0d tests passed, %0d failed, %0d errors in total",
			testsPassed, testsFailed, tbErrs + chkErrs);
		if (testsFailed == 0 && (tbErrs + chkErrs) == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule : tbSpiBridge

//--- files.f
rtl/spiPkg.sv
rtl/wbPkg.sv
rtl/wbSpiCtrl.sv
rtl/spiByteMaster.sv
rtl/spiRxCollect.sv
rtl/spiBridgeTop.sv
bench/spiBridgeChecker.sv
bench/tbSpiBridge.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tbSpiBridge
FILELIST  := files.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJDIR)
